// ==== all.f ====
hw/valu_pkg.sv
hw/vrf_pkg.sv
hw/dsp_slice.sv
hw/alu_lane.sv
hw/wb_arbiter.sv
hw/vector_regfile.sv
hw/valu_top.sv
sim/valu_tb.sv

// ==== hw/alu_lane.sv ====
module alu_lane (
   input  logic              clk,
   input  logic              rstn,
   input  logic              issue_vld_i,
   input  valu_pkg::opmode_t opmode_i,
   input  valu_pkg::sew_t    sew_i,
   input  valu_pkg::elem_t   op1_i,
   input  valu_pkg::elem_t   op2_i,
   input  valu_pkg::elem_t   op3_i,         // addend for macc
   output logic              res_vld_o,
   output valu_pkg::elem_t   res_data_o
);

   logic [valu_pkg::LP_PIPE_STAGES-1:0] vld_q;
   valu_pkg::opmode_t op_s0;
   valu_pkg::opmode_t op_s1;                // multiply alu bits cleared
   valu_pkg::opmode_t op_s2;
   valu_pkg::sew_t    sew_s0;
   valu_pkg::sew_t    sew_s1;
   valu_pkg::sew_t    sew_s2;
   valu_pkg::elem_t   op1_q;
   valu_pkg::elem_t   op2_q;
   valu_pkg::elem_t   op3_q;
   valu_pkg::elem_t   op1_x;                // width adjusted operands
   valu_pkg::elem_t   op2_x;
   valu_pkg::opmode_t cmp_code;
   logic              cmp_next;
   logic [1:0]        cmp_q;
   logic              macc_s0;
   valu_pkg::elem_t   slc_a;
   valu_pkg::elem_t   slc_b;
   valu_pkg::elem_t   slc_c;
   logic [1:0]        xsel;
   logic [1:0]        ysel;
   logic [2:0]        zsel;
   logic [3:0]        alumode;
   logic              p_clr;
   logic [47:0]       p;
   logic              mul_hi_s2;
   valu_pkg::elem_t   res_next;
   valu_pkg::elem_t   res_q;

   // sign or zero extend an element to 32 bits
   function automatic valu_pkg::elem_t fmt_operand(valu_pkg::elem_t v, valu_pkg::sew_t sew,
                                                   logic sext);
      fmt_operand = v;
      if (sew == valu_pkg::LP_SEW_8)
         fmt_operand = sext ? {{24{v[7]}}, v[7:0]} : {24'h0, v[7:0]};
      else if (sew == valu_pkg::LP_SEW_16)
         fmt_operand = sext ? {{16{v[15]}}, v[15:0]} : {16'h0, v[15:0]};
   endfunction

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         vld_q  <= '0;
         op_s0  <= '0;
         op_s1  <= '0;
         op_s2  <= '0;
         sew_s0 <= '0;
         sew_s1 <= '0;
         sew_s2 <= '0;
      end
      else
      begin
         vld_q <= {vld_q[valu_pkg::LP_PIPE_STAGES-2:0], issue_vld_i};
         op_s0 <= opmode_i;
         if (op_s0[6:5] == valu_pkg::LP_CLS_MUL)
            op_s1 <= {op_s0[8:3], 3'b000};  // slice only adds for multiply
         else
            op_s1 <= op_s0;
         op_s2  <= op_s1;
         sew_s0 <= sew_i;
         sew_s1 <= sew_s0;
         sew_s2 <= sew_s1;
      end
   end

   always_ff @(posedge clk)
   begin
      op1_q <= op1_i;
      op2_q <= op2_i;
      op3_q <= op3_i;
      cmp_q <= {cmp_q[0], cmp_next};        // flag rides beside the slice
      res_q <= res_next;
   end

   assign op1_x = fmt_operand(op1_q, sew_s0, op_s0[7]);
   assign op2_x = fmt_operand(op2_q, sew_s0, op_s0[7]);
   assign cmp_code = {op_s0[8], 1'b0, op_s0[6:0]};  // sext bit ignored

   always_comb
   begin
      case (cmp_code)
         valu_pkg::LP_OP_SLT:  cmp_next = signed'(op1_x) < signed'(op2_x);
         valu_pkg::LP_OP_SLTU: cmp_next = op1_x < op2_x;
         valu_pkg::LP_OP_SLE:  cmp_next = signed'(op1_x) <= signed'(op2_x);
         valu_pkg::LP_OP_SLEU: cmp_next = op1_x <= op2_x;
         valu_pkg::LP_OP_SGT:  cmp_next = signed'(op1_x) > signed'(op2_x);
         valu_pkg::LP_OP_SGTU: cmp_next = op1_x > op2_x;
         valu_pkg::LP_OP_SEQ:  cmp_next = op1_x == op2_x;
         valu_pkg::LP_OP_SNE:  cmp_next = op1_x != op2_x;
         default:              cmp_next = 1'b0;
      endcase
   end

   // slice operands in stage 0
   assign macc_s0 = (op_s0[6:5] == valu_pkg::LP_CLS_MUL) && (op_s0[4:3] == 2'b10);
   assign slc_a = (op_s0[6:5] == valu_pkg::LP_CLS_MUL) ? op1_x : {32{op2_x[31]}};
   assign slc_b = op2_x;
   assign slc_c = macc_s0 ? op3_q : op1_x;

   // slice control in stage 1
   always_comb
   begin
      xsel = valu_pkg::LP_X_NORMAL;
      ysel = op_s1[4] ? valu_pkg::LP_Y_ONES : valu_pkg::LP_Y_NORMAL;
      zsel = valu_pkg::LP_Z_NORMAL;
      if (op_s1[6:5] == valu_pkg::LP_CLS_MUL)
      begin
         if (op_s1[4:3] == 2'b10)
         begin
            xsel = valu_pkg::LP_X_MUL_ACC;
            ysel = valu_pkg::LP_Y_MUL_ACC;
            zsel = valu_pkg::LP_Z_MUL_ACC;
         end
         else
         begin
            xsel = valu_pkg::LP_X_MUL;
            ysel = valu_pkg::LP_Y_MUL;
            zsel = valu_pkg::LP_Z_MUL;
         end
      end
   end

   assign alumode = {op_s1[3] & (op_s1[6:5] == valu_pkg::LP_CLS_NORMAL), op_s1[2:0]};
   assign p_clr   = op_s1[6:5] == valu_pkg::LP_CLS_CMP;  // compare result starts from zero

   dsp_slice u_dsp_slice (
      .clk       (clk),
      .rstn      (rstn),
      .a_i       (slc_a),
      .b_i       (slc_b),
      .c_i       (slc_c),
      .xsel_i    (xsel),
      .ysel_i    (ysel),
      .zsel_i    (zsel),
      .alumode_i (alumode),
      .p_clr_i   (p_clr),
      .p_o       (p)
   );

   // result formatting in stage 2
   assign mul_hi_s2 = (op_s2[6:5] == valu_pkg::LP_CLS_MUL) && (op_s2[4:3] == 2'b11);

   always_comb
   begin
      res_next = (op_s2[6:5] == valu_pkg::LP_CLS_CMP) ? {p[31:1], cmp_q[1]} : p[31:0];
      if (sew_s2 == valu_pkg::LP_SEW_8)
         res_next = mul_hi_s2 ? {24'h0, p[15:8]} : {24'h0, res_next[7:0]};
      else if (sew_s2 == valu_pkg::LP_SEW_16)
         res_next = mul_hi_s2 ? {16'h0, p[31:16]} : {16'h0, res_next[15:0]};
   end

   assign res_vld_o  = vld_q[valu_pkg::LP_PIPE_STAGES-1];
   assign res_data_o = res_q;

endmodule

// ==== hw/dsp_slice.sv ====
module dsp_slice (
   input  logic            clk,
   input  logic            rstn,
   input  valu_pkg::elem_t a_i,            // multiplicand and upper part of A:B
   input  valu_pkg::elem_t b_i,            // multiplier and lower part of A:B
   input  valu_pkg::elem_t c_i,
   input  logic [1:0]      xsel_i,
   input  logic [1:0]      ysel_i,
   input  logic [2:0]      zsel_i,
   input  logic [3:0]      alumode_i,
   input  logic            p_clr_i,        // clears P on the next edge
   output logic [47:0]     p_o
);

   logic signed [47:0] a_q;                // input registers
   logic signed [47:0] b_q;
   logic [47:0]        c_q;
   logic signed [47:0] m;                  // product low 48 bits
   logic [47:0]        ab;
   logic [47:0]        x;
   logic [47:0]        y;
   logic [47:0]        z;
   logic [47:0]        p_next;
   logic [47:0]        p_q;

   always_ff @(posedge clk)
   begin
      a_q <= {{16{a_i[31]}}, a_i};         // sign extend into the slice width
      b_q <= {{16{b_i[31]}}, b_i};
      c_q <= {{16{c_i[31]}}, c_i};
   end

   assign m  = a_q * b_q;
   assign ab = {a_q[15:0], b_q[31:0]};     // concatenated A:B operand

   always_comb
   begin
      case (xsel_i)
         valu_pkg::LP_X_MUL:    x = m;
         valu_pkg::LP_X_NORMAL: x = ab;
         default:               x = '0;
      endcase
      case (ysel_i)
         valu_pkg::LP_Y_ONES: y = '1;
         2'b11:               y = c_q;
         default:             y = '0;      // product partner folded into X
      endcase
      case (zsel_i)
         valu_pkg::LP_Z_NORMAL: z = c_q;
         valu_pkg::LP_Z_P:      z = p_q;
         default:               z = '0;
      endcase
   end

   always_comb
   begin
      case (alumode_i)
         valu_pkg::LP_ALU_SUB: p_next = z - (x + y);
         valu_pkg::LP_ALU_XOR: p_next = (ysel_i == valu_pkg::LP_Y_NORMAL) ? x ^ z : ~(x ^ z);
         valu_pkg::LP_ALU_AND: p_next = (ysel_i == valu_pkg::LP_Y_NORMAL) ? x & z : x | z;
         default:              p_next = z + x + y;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rstn || p_clr_i)
      begin
         p_q <= '0;
      end
      else
      begin
         p_q <= p_next;
      end
   end

   assign p_o = p_q;

endmodule

// ==== hw/valu_pkg.sv ====
package valu_pkg;

   typedef logic [31:0] elem_t;                     // one vector element
   typedef logic [8:0]  opmode_t;                   // {cmp ext, sext, class, acc/sel, alu mode}
   typedef logic [2:0]  sew_t;                      // element width code

   localparam int LP_PIPE_STAGES = 4;               // issue to result valid

   localparam sew_t LP_SEW_8  = 3'd0;
   localparam sew_t LP_SEW_16 = 3'd1;
   localparam sew_t LP_SEW_32 = 3'd2;

   localparam logic [1:0] LP_CLS_NORMAL = 2'b00;    // opmode[6:5]
   localparam logic [1:0] LP_CLS_CMP    = 2'b01;
   localparam logic [1:0] LP_CLS_MUL    = 2'b10;

   localparam logic [3:0] LP_ALU_ADD = 4'b0000;     // Z + X + Y
   localparam logic [3:0] LP_ALU_SUB = 4'b0011;     // Z - (X + Y)
   localparam logic [3:0] LP_ALU_XOR = 4'b0100;     // X ^ Z or xnor with Y ones
   localparam logic [3:0] LP_ALU_AND = 4'b1100;     // X & Z or X | Z with Y ones

   localparam opmode_t LP_OP_ADD   = {2'b00, LP_CLS_NORMAL, 1'b0, LP_ALU_ADD};
   localparam opmode_t LP_OP_SUB   = {2'b00, LP_CLS_NORMAL, 1'b0, LP_ALU_SUB};
   localparam opmode_t LP_OP_AND   = {2'b00, LP_CLS_NORMAL, 1'b0, LP_ALU_AND};
   localparam opmode_t LP_OP_OR    = {2'b00, LP_CLS_NORMAL, 1'b1, LP_ALU_AND};
   localparam opmode_t LP_OP_XOR   = {2'b00, LP_CLS_NORMAL, 1'b0, LP_ALU_XOR};
   localparam opmode_t LP_OP_MUL   = 9'h040;
   localparam opmode_t LP_OP_MACC  = 9'h050;        // bit 4 picks op3 as addend
   localparam opmode_t LP_OP_MULHU = 9'h058;        // bits 4 and 3 take the high half
   localparam opmode_t LP_OP_MULH  = 9'h0d8;        // signed so sext is set
   localparam opmode_t LP_OP_SLT   = 9'h020;
   localparam opmode_t LP_OP_SLTU  = 9'h021;
   localparam opmode_t LP_OP_SLE   = 9'h022;
   localparam opmode_t LP_OP_SLEU  = 9'h023;
   localparam opmode_t LP_OP_SGT   = 9'h024;
   localparam opmode_t LP_OP_SGTU  = 9'h025;
   localparam opmode_t LP_OP_SEQ   = 9'h120;        // bit 8 extends the compare codes
   localparam opmode_t LP_OP_SNE   = 9'h121;

   localparam logic [1:0] LP_X_NORMAL  = 2'b11;     // A:B
   localparam logic [1:0] LP_X_MUL     = 2'b01;     // product
   localparam logic [1:0] LP_X_MUL_ACC = 2'b01;
   localparam logic [1:0] LP_Y_NORMAL  = 2'b00;     // zero
   localparam logic [1:0] LP_Y_ONES    = 2'b10;     // all ones for or/xnor
   localparam logic [1:0] LP_Y_MUL     = 2'b01;     // product partner
   localparam logic [1:0] LP_Y_MUL_ACC = 2'b01;
   localparam logic [2:0] LP_Z_NORMAL  = 3'b011;    // C
   localparam logic [2:0] LP_Z_P       = 3'b010;    // P feedback
   localparam logic [2:0] LP_Z_MUL     = 3'b000;    // zero
   localparam logic [2:0] LP_Z_MUL_ACC = 3'b011;    // C carries op3

endpackage

// ==== hw/valu_top.sv ====
module valu_top (
   input  logic                             clk,
   input  logic                             rstn,
   input  logic [vrf_pkg::LP_NUM_LANES-1:0] issue_vld_i,
   input  valu_pkg::opmode_t                opmode_i [vrf_pkg::LP_NUM_LANES],
   input  valu_pkg::sew_t                   sew_i    [vrf_pkg::LP_NUM_LANES],
   input  valu_pkg::elem_t                  op1_i    [vrf_pkg::LP_NUM_LANES],
   input  valu_pkg::elem_t                  op2_i    [vrf_pkg::LP_NUM_LANES],
   input  valu_pkg::elem_t                  op3_i    [vrf_pkg::LP_NUM_LANES],
   input  vrf_pkg::vreg_addr_t              dest_i   [vrf_pkg::LP_NUM_LANES],
   output logic [vrf_pkg::LP_NUM_LANES-1:0] busy_o,
   output logic                             wb_vld_o,
   output vrf_pkg::lane_t                   wb_lane_o,
   output vrf_pkg::vreg_addr_t              wb_addr_o,
   output valu_pkg::elem_t                  wb_data_o,
   input  vrf_pkg::vreg_addr_t              rd_addr_i,
   output valu_pkg::elem_t                  rd_data_o
);

   logic [vrf_pkg::LP_NUM_LANES-1:0] res_vld;
   valu_pkg::elem_t                  res_data [vrf_pkg::LP_NUM_LANES];
   vrf_pkg::vreg_addr_t              res_addr [vrf_pkg::LP_NUM_LANES];

   for (genvar g = 0; g < vrf_pkg::LP_NUM_LANES; g++)
   begin : gen_lane
      vrf_pkg::vreg_addr_t [valu_pkg::LP_PIPE_STAGES-1:0] dest_dly;  // matches lane latency

      always_ff @(posedge clk)
      begin
         dest_dly <= {dest_dly[valu_pkg::LP_PIPE_STAGES-2:0], dest_i[g]};
      end

      assign res_addr[g] = dest_dly[valu_pkg::LP_PIPE_STAGES-1];

      alu_lane u_alu_lane (
         .clk         (clk),
         .rstn        (rstn),
         .issue_vld_i (issue_vld_i[g]),
         .opmode_i    (opmode_i[g]),
         .sew_i       (sew_i[g]),
         .op1_i       (op1_i[g]),
         .op2_i       (op2_i[g]),
         .op3_i       (op3_i[g]),
         .res_vld_o   (res_vld[g]),
         .res_data_o  (res_data[g])
      );
   end

   wb_arbiter u_wb_arbiter (
      .clk         (clk),
      .rstn        (rstn),
      .issue_vld_i (issue_vld_i),
      .res_vld_i   (res_vld),
      .res_addr_i  (res_addr),
      .res_data_i  (res_data),
      .busy_o      (busy_o),
      .wb_vld_o    (wb_vld_o),
      .wb_lane_o   (wb_lane_o),
      .wb_addr_o   (wb_addr_o),
      .wb_data_o   (wb_data_o)
   );

   vector_regfile u_vector_regfile (
      .clk       (clk),
      .wr_en_i   (wb_vld_o),                 // single write port
      .wr_addr_i (wb_addr_o),
      .wr_data_i (wb_data_o),
      .rd_addr_i (rd_addr_i),
      .rd_data_o (rd_data_o)
   );

endmodule

// ==== hw/vector_regfile.sv ====
module vector_regfile (
   input  logic                clk,
   input  logic                wr_en_i,
   input  vrf_pkg::vreg_addr_t wr_addr_i,
   input  valu_pkg::elem_t     wr_data_i,
   input  vrf_pkg::vreg_addr_t rd_addr_i,
   output valu_pkg::elem_t     rd_data_o        // one cycle after rd_addr_i
);

   valu_pkg::elem_t mem [vrf_pkg::LP_NUM_REGS];

   always_ff @(posedge clk)
   begin
      if (wr_en_i)
         mem[wr_addr_i] <= wr_data_i;
      rd_data_o <= mem[rd_addr_i];               // old data on same cycle write
   end

endmodule

// ==== hw/vrf_pkg.sv ====
package vrf_pkg;

   localparam int LP_NUM_REGS    = 32;
   localparam int LP_ADDR_W      = $clog2(LP_NUM_REGS);
   localparam int LP_NUM_LANES   = 2;
   localparam int LP_QUEUE_DEPTH = 4;                     // entries per lane queue
   localparam int LP_PTR_W       = $clog2(LP_QUEUE_DEPTH);
   localparam int LP_CNT_W       = $clog2(LP_QUEUE_DEPTH + 1);

   typedef logic [LP_ADDR_W-1:0] vreg_addr_t;
   typedef logic [$clog2(LP_NUM_LANES)-1:0] lane_t;
   typedef logic [LP_PTR_W-1:0] ptr_t;                    // queue slot index
   typedef logic [LP_CNT_W-1:0] cnt_t;                    // fill level and credits

endpackage

// ==== hw/wb_arbiter.sv ====
module wb_arbiter (
   input  logic                               clk,
   input  logic                               rstn,
   input  logic [vrf_pkg::LP_NUM_LANES-1:0]   issue_vld_i,     // takes a credit
   input  logic [vrf_pkg::LP_NUM_LANES-1:0]   res_vld_i,
   input  vrf_pkg::vreg_addr_t                res_addr_i [vrf_pkg::LP_NUM_LANES],
   input  valu_pkg::elem_t                    res_data_i [vrf_pkg::LP_NUM_LANES],
   output logic [vrf_pkg::LP_NUM_LANES-1:0]   busy_o,
   output logic                               wb_vld_o,
   output vrf_pkg::lane_t                     wb_lane_o,
   output vrf_pkg::vreg_addr_t                wb_addr_o,
   output valu_pkg::elem_t                    wb_data_o
);

   vrf_pkg::vreg_addr_t q_addr [vrf_pkg::LP_NUM_LANES][vrf_pkg::LP_QUEUE_DEPTH];
   valu_pkg::elem_t     q_data [vrf_pkg::LP_NUM_LANES][vrf_pkg::LP_QUEUE_DEPTH];
   vrf_pkg::ptr_t       wr_ptr [vrf_pkg::LP_NUM_LANES];
   vrf_pkg::ptr_t       rd_ptr [vrf_pkg::LP_NUM_LANES];
   vrf_pkg::cnt_t       count  [vrf_pkg::LP_NUM_LANES];      // queue fill
   vrf_pkg::cnt_t       credit [vrf_pkg::LP_NUM_LANES];      // free slots not yet promised
   logic [vrf_pkg::LP_NUM_LANES-1:0] not_empty;
   logic [vrf_pkg::LP_NUM_LANES-1:0] pop;
   vrf_pkg::lane_t      last_q;                               // lowest priority next
   vrf_pkg::lane_t      cand;
   vrf_pkg::lane_t      gnt;
   logic                gnt_vld;

   always_comb
   begin
      for (int n = 0; n < vrf_pkg::LP_NUM_LANES; n++)
      begin
         not_empty[n] = count[n] != '0;
         busy_o[n]    = credit[n] == '0;
      end
   end

   // round robin starting after the last grant
   always_comb
   begin
      gnt_vld = 1'b0;
      gnt     = last_q;
      cand    = last_q;
      for (int i = 1; i <= vrf_pkg::LP_NUM_LANES; i++)
      begin
         cand = vrf_pkg::lane_t'((int'(last_q) + i) % vrf_pkg::LP_NUM_LANES);
         if (!gnt_vld && not_empty[cand])
         begin
            gnt_vld = 1'b1;
            gnt     = cand;
         end
      end
      pop      = '0;
      pop[gnt] = gnt_vld;
   end

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         for (int n = 0; n < vrf_pkg::LP_NUM_LANES; n++)
         begin
            wr_ptr[n] <= '0;
            rd_ptr[n] <= '0;
            count[n]  <= '0;
            credit[n] <= vrf_pkg::cnt_t'(vrf_pkg::LP_QUEUE_DEPTH);
         end
         last_q <= '0;
      end
      else
      begin
         for (int n = 0; n < vrf_pkg::LP_NUM_LANES; n++)
         begin
            if (res_vld_i[n])
               wr_ptr[n] <= wr_ptr[n] + 1'b1;  // wraps at queue depth
            if (pop[n])
               rd_ptr[n] <= rd_ptr[n] + 1'b1;
            count[n]  <= count[n] + res_vld_i[n] - pop[n];
            credit[n] <= credit[n] - issue_vld_i[n] + pop[n];  // back when written
         end
         if (gnt_vld)
            last_q <= gnt;
      end
   end

   always_ff @(posedge clk)
   begin
      for (int n = 0; n < vrf_pkg::LP_NUM_LANES; n++)
      begin
         if (res_vld_i[n])
         begin
            q_addr[n][wr_ptr[n]] <= res_addr_i[n];
            q_data[n][wr_ptr[n]] <= res_data_i[n];
         end
      end
   end

   assign wb_vld_o  = gnt_vld;
   assign wb_lane_o = gnt;
   assign wb_addr_o = q_addr[gnt][rd_ptr[gnt]];            // head of granted queue
   assign wb_data_o = q_data[gnt][rd_ptr[gnt]];

endmodule

// ==== sim/valu_patterns.txt ====
// lane opmode sew op1 op2 op3 dest expected, all hex, one operation per line
// sew 0/1/2 = 8/16/32 bit, expected is the written element zero filled above sew
0 000 2 12345678 11111111 00000000 01 23456789
1 003 2 00000010 00000020 00000000 02 fffffff0
0 00c 2 f0f0f0f0 ff00ff00 00000000 03 f000f000
1 01c 2 f0f0f0f0 0f000f00 00000000 04 fff0fff0
0 004 2 aaaa5555 ffff0000 00000000 05 55555555
1 000 0 abcdeff0 00000020 00000000 06 00000010
0 003 1 12340005 abcd0010 00000000 07 0000fff5
1 080 0 000000ff 000000ff 00000000 08 000000fe
0 040 0 123456ff 00000003 00000000 09 000000fd
1 058 0 000000ff 000000ff 00000000 0a 000000fe
0 0d8 0 000000ff 00000002 00000000 0b 000000ff
1 058 1 0000ffff 00000010 00000000 0c 0000000f
0 0d8 1 00008000 00000003 00000000 0d 0000fffe
1 050 2 00000007 00000006 00000064 0e 0000008e
1 020 2 ffffffff 00000001 00000000 0f 00000001
0 050 2 00010000 00010000 00000005 10 00000005
0 021 2 ffffffff 00000001 00000000 11 00000000
1 022 2 80000000 80000000 00000000 12 00000001
0 023 2 00000005 00000004 00000000 13 00000000
1 024 0 00000080 00000001 00000000 14 00000001
0 0a4 0 00000080 00000001 00000000 15 00000000
1 025 1 0000ffff 00001234 00000000 16 00000001
0 120 1 1111abcd 2222abcd 00000000 17 00000001
1 121 2 1111abcd 2222abcd 00000000 18 00000001

// ==== sim/valu_tb.sv ====
module valu_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int MAX_PAT   = 64;                        // pattern slots
   localparam int PAT_WORDS = 8;                         // hex words per pattern line
   localparam int EXP_DEPTH = 4 * MAX_PAT;               // three passes fit per lane

   logic                             clk;
   logic                             rstn;
   logic [vrf_pkg::LP_NUM_LANES-1:0] issue_vld;
   valu_pkg::opmode_t                opmode [vrf_pkg::LP_NUM_LANES];
   valu_pkg::sew_t                   sew    [vrf_pkg::LP_NUM_LANES];
   valu_pkg::elem_t                  op1    [vrf_pkg::LP_NUM_LANES];
   valu_pkg::elem_t                  op2    [vrf_pkg::LP_NUM_LANES];
   valu_pkg::elem_t                  op3    [vrf_pkg::LP_NUM_LANES];
   vrf_pkg::vreg_addr_t              dest   [vrf_pkg::LP_NUM_LANES];
   logic [vrf_pkg::LP_NUM_LANES-1:0] busy;
   logic                             wb_vld;
   vrf_pkg::lane_t                   wb_lane;
   vrf_pkg::vreg_addr_t              wb_addr;
   valu_pkg::elem_t                  wb_data;
   vrf_pkg::vreg_addr_t              rd_addr;
   valu_pkg::elem_t                  rd_data;

   logic [31:0]         pat_mem [PAT_WORDS*MAX_PAT];     // lane op sew op1 op2 op3 dest exp
   int                  num_pat;
   int                  seed = 73979;
   vrf_pkg::vreg_addr_t exp_addr [vrf_pkg::LP_NUM_LANES][EXP_DEPTH];
   valu_pkg::elem_t     exp_data [vrf_pkg::LP_NUM_LANES][EXP_DEPTH];
   int                  head [vrf_pkg::LP_NUM_LANES];     // next expected write per lane
   int                  tail [vrf_pkg::LP_NUM_LANES];
   int                  credit [vrf_pkg::LP_NUM_LANES];   // model of the arbiter credits
   valu_pkg::elem_t     reg_model [vrf_pkg::LP_NUM_REGS];
   logic                written [vrf_pkg::LP_NUM_REGS];
   logic                busy_seen;

   valu_top u_valu_top (
      .clk         (clk),
      .rstn        (rstn),
      .issue_vld_i (issue_vld),
      .opmode_i    (opmode),
      .sew_i       (sew),
      .op1_i       (op1),
      .op2_i       (op2),
      .op3_i       (op3),
      .dest_i      (dest),
      .busy_o      (busy),
      .wb_vld_o    (wb_vld),
      .wb_lane_o   (wb_lane),
      .wb_addr_o   (wb_addr),
      .wb_data_o   (wb_data),
      .rd_addr_i   (rd_addr),
      .rd_data_o   (rd_data)
   );

   always #4 clk = ~clk;                                 // 8 ns period

   task automatic abort_run();
      $display("SIMULATION FAILED");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input valu_pkg::elem_t exp,
                             input valu_pkg::elem_t act);
      if (act !== exp)
      begin
         $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_addr(input string name, input vrf_pkg::vreg_addr_t exp,
                             input vrf_pkg::vreg_addr_t act);
      if (act !== exp)
      begin
         $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_busy(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("MISMATCH time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
         abort_run();
      end
   endtask

   // results still owed by the DUT
   function automatic int pending();
      int total;
      total = 0;
      for (int n = 0; n < vrf_pkg::LP_NUM_LANES; n++)
         total += tail[n] - head[n];
      return total;
   endfunction

   task automatic next_cycle();
      @(posedge clk);
      #1;                                                // drive just after the edge
      issue_vld = '0;
   endtask

   // put pattern idx on lane ln and remember what must come back
   task automatic issue_pat(input int ln, input int idx);
      int b;
      b = PAT_WORDS * idx;
      issue_vld[ln] = 1'b1;
      opmode[ln]    = pat_mem[b+1][8:0];
      sew[ln]       = pat_mem[b+2][2:0];
      op1[ln]       = pat_mem[b+3];
      op2[ln]       = pat_mem[b+4];
      op3[ln]       = pat_mem[b+5];
      dest[ln]      = pat_mem[b+6][4:0];
      exp_addr[ln][tail[ln]] = pat_mem[b+6][4:0];
      exp_data[ln][tail[ln]] = pat_mem[b+7];
      tail[ln]++;
   endtask

   task automatic drain();
      while (pending() != 0)
         next_cycle();
   endtask

   // each lane issues num_pat ops on every free cycle or on random gaps
   task automatic burst(input logic rand_gaps);
      int cnt [vrf_pkg::LP_NUM_LANES];
      int idx;
      for (int n = 0; n < vrf_pkg::LP_NUM_LANES; n++)
         cnt[n] = 0;
      while (cnt[0] < num_pat || cnt[1] < num_pat)
      begin
         next_cycle();
         for (int n = 0; n < vrf_pkg::LP_NUM_LANES; n++)
         begin
            if (cnt[n] < num_pat && !busy[n] && (!rand_gaps || ($random(seed) & 1) == 1))
            begin
               if (rand_gaps)
                  idx = ($random(seed) & 32'h7fff_ffff) % num_pat;
               else
                  idx = (cnt[n] + n * (num_pat / 2)) % num_pat;  // lanes walk offset copies
               issue_pat(n, idx);
               cnt[n]++;
            end
         end
      end
      next_cycle();
      drain();
   endtask

   task automatic read_back();
      for (int a = 0; a < vrf_pkg::LP_NUM_REGS; a++)
      begin
         if (written[a])
         begin
            next_cycle();
            rd_addr = vrf_pkg::vreg_addr_t'(a);
            @(posedge clk);                              // registered read
            @(negedge clk);
            check_data($sformatf("rd_data_o[%0d]", a), reg_model[a], rd_data);
         end
      end
   endtask

   // write-back and busy monitor at mid cycle where outputs are settled
   always @(negedge clk)
   begin
      int ln;
      if (rstn)
      begin
         for (int n = 0; n < vrf_pkg::LP_NUM_LANES; n++)
         begin
            check_busy($sformatf("busy_o[%0d]", n), credit[n] == 0, busy[n]);
            if (issue_vld[n] && busy[n])
            begin
               $display("lane %0d was issued to while busy at time %0t", n, $time);
               abort_run();
            end
         end
         if (wb_vld)
         begin
            ln = wb_lane;
            if (head[ln] == tail[ln])
            begin
               $display("unexpected write from lane %0d at time %0t, nothing outstanding",
                        ln, $time);
               abort_run();
            end
            check_addr("wb_addr_o", exp_addr[ln][head[ln]], wb_addr);
            check_data("wb_data_o", exp_data[ln][head[ln]], wb_data);
            reg_model[wb_addr] = exp_data[ln][head[ln]];
            written[wb_addr]   = 1'b1;
            head[ln]++;
         end
         if (busy != '0)
            busy_seen = 1'b1;
         for (int n = 0; n < vrf_pkg::LP_NUM_LANES; n++)
            credit[n] = credit[n] - issue_vld[n] + (wb_vld && wb_lane == n);  // credit model
      end
   end

   initial
   begin
      wait (num_pat > 0);
      repeat ((num_pat + 20) * 20) @(posedge clk);
      $display("timeout after %0d cycles, results still outstanding: %0d",
               (num_pat + 20) * 20, pending());
      abort_run();
   end

   initial
   begin
      clk       = 1'b0;
      rstn      = 1'b0;
      issue_vld = '0;
      rd_addr   = '0;
      num_pat   = 0;
      busy_seen = 1'b0;
      for (int n = 0; n < vrf_pkg::LP_NUM_LANES; n++)
      begin
         opmode[n] = '0;
         sew[n]    = '0;
         op1[n]    = '0;
         op2[n]    = '0;
         op3[n]    = '0;
         dest[n]   = '0;
         head[n]   = 0;
         tail[n]   = 0;
         credit[n] = vrf_pkg::LP_QUEUE_DEPTH;
      end
      for (int a = 0; a < vrf_pkg::LP_NUM_REGS; a++)
      begin
         written[a]   = 1'b0;
         reg_model[a] = '0;
      end
      $readmemh("sim/valu_patterns.txt", pat_mem);
      while (num_pat < MAX_PAT && !$isunknown(pat_mem[PAT_WORDS*num_pat]))
         num_pat++;                                      // unfilled slots stay x
      if (num_pat == 0)
      begin
         $display("no patterns could be read from sim/valu_patterns.txt");
         abort_run();
      end
      repeat (3) @(posedge clk);
      #1;
      rstn = 1'b1;
      // directed pass with each pattern on its own lane in file order
      for (int i = 0; i < num_pat; i++)
      begin
         next_cycle();
         while (busy[pat_mem[PAT_WORDS*i][0]])
            next_cycle();
         issue_pat(pat_mem[PAT_WORDS*i][0], i);
      end
      next_cycle();
      drain();
      burst(1'b0);                                       // both lanes every cycle
      burst(1'b1);                                       // random gaps and lane mix
      read_back();
      if (!busy_seen)
      begin
         $display("busy_o never rose while both lanes were issuing");
         abort_run();
      end
      else
      begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

endmodule
